/* source/fp_format_pkg.sv */
package fp_format_pkg;

  // IEEE-754 double fields
  localparam int dbl_exp_w = 11;
  localparam int dbl_man_w = 52;

  // IEEE-754 single fields
  localparam int sgl_exp_w = 8;
  localparam int sgl_man_w = 23;

  localparam int dbl_bias = 1023;
  localparam int sgl_bias = 127;

  // Biased double exponent thresholds for a single result
  // 897 maps to single exponent -126, the smallest normal
  localparam int sgl_norm_min_dexp = 897;
  // Lowest exponent the alignment table resolves, below it is far tiny
  localparam int sgl_denorm_min_dexp = 872;
  // 1150 maps to single exponent +127
  localparam int sgl_norm_max_dexp = 1150;

  // Operand class of the incoming double
  typedef enum logic [2:0] {
    zero,
    subnorm,
    normal,
    inf,
    qnan,
    snan
  } op_class_e;

  // Where the double exponent falls relative to the single range
  typedef enum logic [1:0] {
    rng_normal,
    rng_denorm,
    rng_far_tiny,
    rng_over
  } range_e;

endpackage

/* source/fcvt_ctrl_pkg.sv */
package fcvt_ctrl_pkg;

  // RISC-V static rounding modes
  typedef enum logic [2:0] {
    rne = 3'd0,
    rtz = 3'd1,
    rdn = 3'd2,
    rup = 3'd3,
    rmm = 3'd4
  } rm_e;

  // Exception flags, no divide by zero for a conversion
  typedef struct packed {
    logic nv;
    logic of;
    logic uf;
    logic nx;
  } fflags_t;

  typedef struct packed {
    logic [63:0] op;
    rm_e         rm;
  } fcvt_req_t;

  // Stage 1 to stage 2 payload
  typedef struct packed {
    logic                                sign;
    fp_format_pkg::op_class_e            cls;
    fp_format_pkg::range_e               rng;
    logic [fp_format_pkg::dbl_exp_w-1:0] dexp;
    logic [fp_format_pkg::dbl_man_w-1:0] man;
    rm_e                                 rm;
  } fcvt_s1_t;

  typedef struct packed {
    logic [31:0] result;
    fflags_t     flags;
  } fcvt_res_t;

  // RISC-V canonical quiet NaN
  localparam logic [31:0] canon_nan = 32'h7fc00000;

endpackage

/* source/fcvt_dtos_denorm_shift.sv */
`timescale 1ns/1ps

module fcvt_dtos_denorm_shift (
  input  logic [10:0] sh_cnt,
  input  logic [51:0] sh_src,
  output logic [23:0] sh_kept,
  output logic [53:0] sh_out
);

  logic        in_table;
  logic [4:0]  sh_amt;
  logic [77:0] aligned;

  // Table window is biased exponent 872 up to 896
  // 896 is single exponent -127 and shifts by one place,
  // each step down adds one more place, 872 shifts by 25
  assign in_table = (sh_cnt >= 11'(fp_format_pkg::sgl_denorm_min_dexp)) &&
                    (sh_cnt < 11'(fp_format_pkg::sgl_norm_min_dexp));

  // Only meaningful inside the window, where it spans 1 to 25
  assign sh_amt = 5'(11'(fp_format_pkg::sgl_norm_min_dexp) - sh_cnt);

  // Hidden one on top of the fraction, kept field is the top 24 bits
  // and everything below it is guard then sticky
  assign aligned = {1'b1, sh_src, 25'd0} >> sh_amt;

  // Examples of the mapping
  //   896: kept = {0, 1, frac[51:30]}, out = {frac[29:0], 0...}
  //   874: kept = 1,                   out = {frac[51:0], 00}
  //   873: kept = 0,                   out = {1, frac[51:0], 0}
  //   872: kept = 0,                   out = {0, 1, frac[51:0]}
  always_comb begin
    if (in_table) begin
      sh_kept = aligned[77:54];
      sh_out  = aligned[53:0];
    end else begin
      // Far tiny, nothing kept and no guard, just a sticky bit
      sh_kept = '0;
      sh_out  = {3'b001, 51'd0};
    end
  end

endmodule

/* source/fcvt_dtos_unpack.sv */
`timescale 1ns/1ps

module fcvt_dtos_unpack (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_valid,
  input  fcvt_ctrl_pkg::fcvt_req_t in_req,
  output logic                     s1_valid,
  output fcvt_ctrl_pkg::fcvt_s1_t  s1
);

  logic                                sign;
  logic [fp_format_pkg::dbl_exp_w-1:0] dexp;
  logic [fp_format_pkg::dbl_man_w-1:0] man;
  logic                                exp_zero;
  logic                                exp_ones;
  logic                                man_zero;
  fp_format_pkg::op_class_e            cls;
  fp_format_pkg::range_e               rng;
  fcvt_ctrl_pkg::fcvt_s1_t             s1_next;

  // Field split of the double
  assign sign = in_req.op[63];
  assign dexp = in_req.op[fp_format_pkg::dbl_man_w +: fp_format_pkg::dbl_exp_w];
  assign man  = in_req.op[fp_format_pkg::dbl_man_w-1:0];

  assign exp_zero = (dexp == '0);
  assign exp_ones = (dexp == '1);
  assign man_zero = (man == '0);

  // Operand class
  always_comb begin
    if (exp_ones) begin
      if (man_zero) begin
        cls = fp_format_pkg::inf;
      end else if (man[fp_format_pkg::dbl_man_w-1]) begin
        // Quiet bit set
        cls = fp_format_pkg::qnan;
      end else begin
        cls = fp_format_pkg::snan;
      end
    end else if (exp_zero) begin
      cls = man_zero ? fp_format_pkg::zero : fp_format_pkg::subnorm;
    end else begin
      cls = fp_format_pkg::normal;
    end
  end

  // Result range, double subnormals fall into far tiny via exponent 0
  always_comb begin
    if (dexp > 11'(fp_format_pkg::sgl_norm_max_dexp)) begin
      rng = fp_format_pkg::rng_over;
    end else if (dexp >= 11'(fp_format_pkg::sgl_norm_min_dexp)) begin
      rng = fp_format_pkg::rng_normal;
    end else if (dexp >= 11'(fp_format_pkg::sgl_denorm_min_dexp)) begin
      rng = fp_format_pkg::rng_denorm;
    end else begin
      rng = fp_format_pkg::rng_far_tiny;
    end
  end

  always_comb begin
    s1_next.sign = sign;
    s1_next.cls  = cls;
    s1_next.rng  = rng;
    s1_next.dexp = dexp;
    s1_next.man  = man;
    s1_next.rm   = in_req.rm;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  // Payload only loads on a valid item
  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1 <= s1_next;
    end
  end

endmodule

/* source/fcvt_dtos_round.sv */
`timescale 1ns/1ps

module fcvt_dtos_round (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     s1_valid,
  input  fcvt_ctrl_pkg::fcvt_s1_t  s1,
  output logic                     out_valid,
  output fcvt_ctrl_pkg::fcvt_res_t out_res
);

  logic [23:0] sh_kept;
  logic [53:0] sh_out;

  logic [fp_format_pkg::sgl_exp_w-1:0]                         exp_n;
  logic [fp_format_pkg::sgl_exp_w+fp_format_pkg::sgl_man_w-1:0] base;
  logic [fp_format_pkg::sgl_exp_w+fp_format_pkg::sgl_man_w-1:0] rounded;
  logic                                                         guard;
  logic                                                         sticky;
  logic                                                         inexact;
  logic                                                         tiny;
  logic                                                         round_up;
  logic                                                         ovf;
  logic                                                         to_max;
  fcvt_ctrl_pkg::fcvt_res_t                                     res_next;

  fcvt_dtos_denorm_shift u_denorm_shift (
    .sh_cnt  (s1.dexp),
    .sh_src  (s1.man),
    .sh_kept (sh_kept),
    .sh_out  (sh_out)
  );

  // Rebias double exponent to single, only used in the normal range
  assign exp_n = 8'(s1.dexp - 11'(fp_format_pkg::dbl_bias - fp_format_pkg::sgl_bias));

  // Exponent and mantissa held together so a mantissa carry bumps the exponent
  always_comb begin
    if (s1.rng == fp_format_pkg::rng_normal) begin
      base   = {exp_n, s1.man[51:29]};
      guard  = s1.man[28];
      sticky = |s1.man[27:0];
    end else begin
      // Kept bit 23 is always clear here, so the exponent field starts at 0
      base   = {7'd0, sh_kept};
      guard  = sh_out[53];
      sticky = |sh_out[52:0];
    end
  end

  assign inexact = guard | sticky;
  assign tiny    = (s1.rng == fp_format_pkg::rng_denorm) ||
                   (s1.rng == fp_format_pkg::rng_far_tiny);

  always_comb begin
    case (s1.rm)
      fcvt_ctrl_pkg::rne: round_up = guard & (sticky | base[0]);
      fcvt_ctrl_pkg::rtz: round_up = 1'b0;
      fcvt_ctrl_pkg::rdn: round_up = s1.sign & inexact;
      fcvt_ctrl_pkg::rup: round_up = ~s1.sign & inexact;
      fcvt_ctrl_pkg::rmm: round_up = guard;
      default:            round_up = 1'b0;
    endcase
  end

  // Largest subnormal plus one lands on 0x00800000 by itself
  assign rounded = base + 31'(round_up);

  assign ovf = (s1.rng == fp_format_pkg::rng_over) || (&rounded[30:23]);

  // Modes that round toward zero for this sign saturate to max finite
  assign to_max = (s1.rm == fcvt_ctrl_pkg::rtz) ||
                  ((s1.rm == fcvt_ctrl_pkg::rdn) && !s1.sign) ||
                  ((s1.rm == fcvt_ctrl_pkg::rup) && s1.sign);

  always_comb begin
    res_next.flags  = '0;
    res_next.result = '0;
    case (s1.cls)
      fp_format_pkg::qnan: begin
        res_next.result = fcvt_ctrl_pkg::canon_nan;
      end
      fp_format_pkg::snan: begin
        res_next.result   = fcvt_ctrl_pkg::canon_nan;
        res_next.flags.nv = 1'b1;
      end
      fp_format_pkg::inf: begin
        res_next.result = {s1.sign, 8'hff, 23'd0};
      end
      fp_format_pkg::zero: begin
        res_next.result = {s1.sign, 31'd0};
      end
      default: begin
        // Normal and subnormal doubles
        if (ovf) begin
          res_next.result   = to_max ? {s1.sign, 31'h7f7fffff} : {s1.sign, 31'h7f800000};
          res_next.flags.of = 1'b1;
          res_next.flags.nx = 1'b1;
        end else begin
          res_next.result   = {s1.sign, rounded};
          res_next.flags.nx = inexact;
          // Tininess before rounding
          res_next.flags.uf = tiny & inexact;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      out_res <= res_next;
    end
  end

endmodule

/* source/fcvt_top.sv */
`timescale 1ns/1ps

module fcvt_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_valid,
  input  fcvt_ctrl_pkg::fcvt_req_t in_req,
  output logic                     out_valid,
  output fcvt_ctrl_pkg::fcvt_res_t out_res
);

  // Stage 1 to stage 2
  logic                    s1_valid;
  fcvt_ctrl_pkg::fcvt_s1_t s1;

  // Classify and range check
  fcvt_dtos_unpack u_unpack (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_req   (in_req),
    .s1_valid (s1_valid),
    .s1       (s1)
  );

  // Align, round and pack
  fcvt_dtos_round u_round (
    .clk       (clk),
    .reset     (reset),
    .s1_valid  (s1_valid),
    .s1        (s1),
    .out_valid (out_valid),
    .out_res   (out_res)
  );

endmodule

/* tb/fcvt_checker.sv */
`timescale 1ns/1ps

module fcvt_checker (
  input logic                     clk,
  input logic                     reset,
  input logic                     in_valid,
  input logic                     out_valid,
  input fcvt_ctrl_pkg::fcvt_res_t out_res
);

  // Valid drops on the edge that sees reset
  a_reset_clears_valid: assert property (
    @(posedge clk) reset |=> !out_valid
  ) else $error("out_valid high after a reset cycle");

  // Fixed two stage latency
  a_latency: assert property (
    @(posedge clk) disable iff (reset) out_valid == $past(in_valid, 2)
  ) else $error("out_valid does not follow in_valid by two cycles");

  a_nv_gives_nan: assert property (
    @(posedge clk) disable iff (reset)
      (out_valid && out_res.flags.nv) |-> (out_res.result == fcvt_ctrl_pkg::canon_nan)
  ) else $error("nv raised without the canonical NaN result");

  // Overflow is always inexact
  a_of_gives_nx: assert property (
    @(posedge clk) disable iff (reset)
      (out_valid && out_res.flags.of) |-> out_res.flags.nx
  ) else $error("of raised without nx");

endmodule

bind fcvt_top fcvt_checker u_checker (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .out_res   (out_res)
);

/* tb/fcvt_tb.sv */
`timescale 1ns/1ps

module fcvt_tb;

  localparam int drain_limit = 200;
  localparam int reset_cycles = 16;

  logic                     clk;
  logic                     reset;
  logic                     in_valid;
  fcvt_ctrl_pkg::fcvt_req_t in_req;
  logic                     out_valid;
  fcvt_ctrl_pkg::fcvt_res_t out_res;

  // Results still owed by the DUT, oldest first, with their trace line
  fcvt_ctrl_pkg::fcvt_res_t exp_q[$];
  int                       line_q[$];
  fcvt_ctrl_pkg::fcvt_res_t mon_exp;
  int                       mon_line;
  int                       checked;

  fcvt_top dut_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_res   (out_res)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string what, input int line_no,
                             input logic [31:0] got, input logic [31:0] expected);
    if (got !== expected) begin
      $display("[FAIL] time %0t: trace line %0d %s is %h, expected %h",
               $time, line_no, what, got, expected);
      $display("** FAIL **");
      $fatal(1, "Result mismatch");
    end
  endtask

  // Holds one operand on the inputs for a single cycle
  task automatic send_request(input logic [2:0] rm, input logic [63:0] op);
    in_valid  = 1'b1;
    in_req.op = op;
    in_req.rm = fcvt_ctrl_pkg::rm_e'(rm);
    @(posedge clk);
    #1;
  endtask

  // Pop and compare one expected entry per result
  always @(negedge clk) begin
    if (!reset && out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Error at time %0t: the DUT produced a result with no request outstanding",
                 $time);
        $display("** FAIL **");
        $fatal(1, "Unexpected result");
      end else begin
        mon_exp  = exp_q.pop_front();
        mon_line = line_q.pop_front();
        check_value("result", mon_line, out_res.result, mon_exp.result);
        check_value("flags", mon_line, {28'd0, out_res.flags}, {28'd0, mon_exp.flags});
        checked++;
      end
    end
  end

  initial begin
    int                       fd;
    int                       code;
    int                       line_no;
    int                       gap;
    int                       waited;
    string                    line;
    logic [2:0]               rm_v;
    logic [63:0]              op_v;
    logic [31:0]              res_v;
    logic [3:0]               flg_v;
    fcvt_ctrl_pkg::fcvt_res_t exp_v;

    // Early reset cycles carry valid items that must never reach out_valid
    in_valid = 1'b1;
    in_req   = '0;
    reset    = 1'b1;
    checked  = 0;
    line_no  = 0;
    void'($urandom(89681));

    fd = $fopen("tb/fcvt_trace.txt", "r");
    if (fd == 0) begin
      $display("Error: the trace file tb/fcvt_trace.txt could not be opened");
      $display("** FAIL **");
      $fatal(1, "Missing trace file");
    end

    repeat (reset_cycles / 2) @(posedge clk);
    #1;
    in_valid = 1'b0;
    repeat (reset_cycles / 2) @(posedge clk);
    #1;
    reset = 1'b0;

    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      line_no++;
      // Skip blank lines and the column notes
      if (code != 0 && line.len() > 1 && line[0] != "#") begin
        if ($sscanf(line, "%h %h %h %h", rm_v, op_v, res_v, flg_v) != 4) begin
          $display("Error: line %0d of the trace file could not be parsed", line_no);
          $display("** FAIL **");
          $fatal(1, "Bad trace line");
        end
        // Zero gap gives back to back requests
        gap = $urandom_range(2, 0);
        in_valid = 1'b0;
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
        exp_v.result = res_v;
        exp_v.flags  = flg_v;
        exp_q.push_back(exp_v);
        line_q.push_back(line_no);
        send_request(rm_v, op_v);
      end
    end
    in_valid = 1'b0;
    $fclose(fd);

    waited = 0;
    while (exp_q.size() != 0 && waited < drain_limit) begin
      @(posedge clk);
      waited++;
    end

    if (exp_q.size() != 0) begin
      $display("Error: %0d results did not come out of the DUT within %0d cycles",
               exp_q.size(), drain_limit);
      $display("** FAIL **");
      $fatal(1, "Drain timeout");
    end else begin
      $display("Checked %0d conversions", checked);
      $display("** PASS **");
      $finish;
    end
  end

endmodule

/* tb/fcvt_trace.txt */
# Each line holds rounding mode, double operand, expected single and flags {nv of uf nx}
# Rounding modes 0 rne 1 rtz 2 rdn 3 rup 4 rmm
0 3ff0000000000000 3f800000 0
0 c004000000000000 c0200000 0
0 3ff0000010000001 3f800001 1
1 3ff0000010000001 3f800000 1
2 3ff0000010000001 3f800000 1
3 3ff0000010000001 3f800001 1
4 3ff0000010000001 3f800001 1
2 bff0000010000001 bf800001 1
3 bff0000010000001 bf800000 1
0 3ff0000010000000 3f800000 1
4 3ff0000010000000 3f800001 1
0 3ff0000030000000 3f800002 1
0 3ff0000000000001 3f800000 1
3 3ff0000000000001 3f800001 1
0 3810000000000000 00800000 0
0 3800000000000000 00400000 0
0 380fffffffffffff 00800000 3
1 380fffffffffffff 007fffff 3
0 3708000000000000 00000060 0
0 3700200000000000 00000040 3
4 3700200000000000 00000041 3
0 36a0000000000000 00000001 0
0 3690000000000000 00000000 3
0 3690000000000001 00000001 3
4 b690000000000000 80000001 3
0 3680000000000000 00000000 3
3 3680000000000000 00000001 3
0 0640000000000000 00000000 3
3 0640000000000000 00000001 3
2 8640000000000000 80000001 3
1 8640000000000000 80000000 3
0 0000000000000001 00000000 3
2 8000000000000001 80000001 3
0 47f0000000000000 7f800000 5
1 47f0000000000000 7f7fffff 5
2 47f0000000000000 7f7fffff 5
2 c7f0000000000000 ff800000 5
3 c7f0000000000000 ff7fffff 5
0 47efffffffffffff 7f800000 5
1 47efffffffffffff 7f7fffff 1
0 47efffffe0000000 7f7fffff 0
0 7ff8000000000000 7fc00000 0
0 fff8000000000000 7fc00000 0
0 7ff0000000000001 7fc00000 8
0 7ff0000000000000 7f800000 0
0 fff0000000000000 ff800000 0
0 0000000000000000 00000000 0
1 8000000000000000 80000000 0

/* vlog.f */
source/fp_format_pkg.sv
source/fcvt_ctrl_pkg.sv
source/fcvt_dtos_denorm_shift.sv
source/fcvt_dtos_unpack.sv
source/fcvt_dtos_round.sv
source/fcvt_top.sv
tb/fcvt_checker.sv
tb/fcvt_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the FCVT.S.D testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --top-module fcvt_tb -f vlog.f -o fcvt_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/fcvt_sim > sim.log 2>&1
cat sim.log

grep -q '\*\* FAIL \*\*' sim.log && { echo "Simulation failed"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation finished cleanly"
